// ==== include/legv8_macros.svh ====
`ifndef LEGV8_MACROS_SVH
`define LEGV8_MACROS_SVH

`define WORD_W    64
`define REG_COUNT 32
`define RESET_PC  64'h0
`define LINK_REG  5'd30

// r-type
`define ADD    11'b10001011000
`define ADDS   11'b10101011000
`define SUB    11'b11001011000
`define SUBS   11'b11101011000
`define AND    11'b10001010000
`define ANDS   11'b11101010000
`define ORR    11'b10101010000
`define EOR    11'b11001010000

// i-type, lowest opcode bit belongs to the immediate
`define ADDI   11'b1001000100?
`define ADDIS  11'b1011000100?
`define SUBI   11'b1101000100?
`define SUBIS  11'b1111000100?
`define ANDI   11'b1001001000?
`define ANDIS  11'b1111001000?
`define ORRI   11'b1011001000?
`define EORI   11'b1101001000?

// d-type
`define LDUR   11'b11111000010
`define LDURB  11'b00111000010
`define LDURH  11'b01111000010
`define LDURSW 11'b10111000100
`define STUR   11'b11111000000
`define STURB  11'b00111000000
`define STURH  11'b01111000000
`define STURW  11'b10111000000

// b and cb types
`define B      11'b000101?????
`define BL     11'b100101?????
`define CBZ    11'b10110100???
`define CBNZ   11'b10110101???
`define BCOND  11'b01010100???
`define BR     11'b11010110000

`endif

// ==== logic/legv8_pkg.sv ====
`include "legv8_macros.svh"

package legv8_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [31:0]        instr_t;
    typedef logic [3:0]         nzcv_t;  // n z c v from the msb down

    typedef enum logic [1:0] {
        ALU_OP_ADDR = 2'b00,
        ALU_OP_PASS = 2'b01,
        ALU_OP_FUNC = 2'b10
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU  = 2'b00,
        WB_MEM  = 2'b01,
        WB_PC4  = 2'b10
    } mem_to_reg_t;

    typedef enum logic [2:0] {
        BR_NONE     = 3'b000,
        BR_ALWAYS   = 3'b001,
        BR_COND     = 3'b010,
        BR_ZERO     = 3'b011,
        BR_NOT_ZERO = 3'b100,
        BR_REG      = 3'b101  // branch to register
    } branch_op_t;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'h0,
        ALU_SUB    = 4'h1,
        ALU_AND    = 4'h2,
        ALU_ORR    = 4'h3,
        ALU_EOR    = 4'h4,
        ALU_PASS_B = 4'h5
    } alu_func_t;

endpackage

// ==== logic/control.sv ====
`timescale 1ns/1ps
`include "legv8_macros.svh"

module control (
    input  logic [10:0]              opcode,
    output logic                     readreg2_control,
    output logic                     mem_read,
    output logic                     mem_write,
    output logic                     reg_write,
    output logic                     alu_src,
    output logic                     update_sreg,
    output logic                     write_reg_src,
    output legv8_pkg::alu_op_t       alu_op,
    output legv8_pkg::mem_to_reg_t   mem_to_reg,
    output legv8_pkg::branch_op_t    branch_op
);

    always_comb begin
        readreg2_control = 1'b0;
        mem_read         = 1'b0;
        mem_write        = 1'b0;
        reg_write        = 1'b0;
        alu_src          = 1'b0;
        update_sreg      = 1'b0;
        write_reg_src    = 1'b0;
        alu_op           = legv8_pkg::ALU_OP_ADDR;
        mem_to_reg       = legv8_pkg::WB_ALU;
        branch_op        = legv8_pkg::BR_NONE;

        // cmp and cmpi are subs/subis with rd = xzr, the write is dropped
        casez (opcode)
            `ADD, `SUB, `AND, `ORR, `EOR: begin
                reg_write = 1'b1;
                alu_op    = legv8_pkg::ALU_OP_FUNC;
            end
            `ADDS, `SUBS, `ANDS: begin
                reg_write   = 1'b1;
                alu_op      = legv8_pkg::ALU_OP_FUNC;
                update_sreg = 1'b1;
            end
            `ADDI, `SUBI, `ANDI, `ORRI, `EORI: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = legv8_pkg::ALU_OP_FUNC;
            end
            `ADDIS, `SUBIS, `ANDIS: begin
                reg_write   = 1'b1;
                alu_src     = 1'b1;
                alu_op      = legv8_pkg::ALU_OP_FUNC;
                update_sreg = 1'b1;
            end
            `LDUR, `LDURB, `LDURH, `LDURSW: begin
                mem_read   = 1'b1;
                mem_to_reg = legv8_pkg::WB_MEM;
                reg_write  = 1'b1;
                alu_src    = 1'b1;   // base + 9-bit offset
            end
            `STUR, `STURB, `STURH, `STURW: begin
                readreg2_control = 1'b1;  // store data comes from rt
                mem_write        = 1'b1;
                alu_src          = 1'b1;
            end
            `CBZ, `CBNZ: begin
                readreg2_control = 1'b1;
                alu_op           = legv8_pkg::ALU_OP_PASS;
                update_sreg      = 1'b1;
                branch_op        = opcode[3] ? legv8_pkg::BR_NOT_ZERO : legv8_pkg::BR_ZERO;
            end
            `B: begin
                alu_op    = legv8_pkg::ALU_OP_PASS;
                branch_op = legv8_pkg::BR_ALWAYS;
            end
            `BCOND: begin
                alu_op    = legv8_pkg::ALU_OP_PASS;
                branch_op = legv8_pkg::BR_COND;
            end
            `BL: begin
                alu_op        = legv8_pkg::ALU_OP_PASS;
                branch_op     = legv8_pkg::BR_ALWAYS;
                reg_write     = 1'b1;
                mem_to_reg    = legv8_pkg::WB_PC4;
                write_reg_src = 1'b1;   // x30
            end
            `BR: begin
                readreg2_control = 1'b1;
                alu_op           = legv8_pkg::ALU_OP_PASS;
                branch_op        = legv8_pkg::BR_REG;
            end
            default: ;
        endcase
    end

    // one data port, so a load and a store can never share a cycle
    assert final (!(mem_read && mem_write))
        else $error("control: mem_read and mem_write high together");

endmodule

// ==== logic/alu_control.sv ====
`timescale 1ns/1ps
`include "legv8_macros.svh"

module alu_control (
    input  legv8_pkg::alu_op_t   alu_op,
    input  logic [10:0]          opcode,
    output legv8_pkg::alu_func_t alu_func
);

    always_comb begin
        case (alu_op)
            legv8_pkg::ALU_OP_ADDR: alu_func = legv8_pkg::ALU_ADD;
            legv8_pkg::ALU_OP_PASS: alu_func = legv8_pkg::ALU_PASS_B;  // zero test for cbz/cbnz
            default: begin
                casez (opcode)
                    `ADD, `ADDS, `ADDI, `ADDIS: begin
                        alu_func = legv8_pkg::ALU_ADD;
                    end
                    `SUB, `SUBS, `SUBI, `SUBIS: begin
                        alu_func = legv8_pkg::ALU_SUB;  // also cmp, cmpi
                    end
                    `AND, `ANDS, `ANDI, `ANDIS: begin
                        alu_func = legv8_pkg::ALU_AND;
                    end
                    `ORR, `ORRI: begin
                        alu_func = legv8_pkg::ALU_ORR;
                    end
                    `EOR, `EORI: begin
                        alu_func = legv8_pkg::ALU_EOR;
                    end
                    default: begin
                        alu_func = legv8_pkg::ALU_ADD;
                    end
                endcase
            end
        endcase
    end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`include "legv8_macros.svh"

module alu (
    input  legv8_pkg::word_t     a,
    input  legv8_pkg::word_t     b,
    input  legv8_pkg::alu_func_t alu_func,
    output legv8_pkg::word_t     result,
    output legv8_pkg::nzcv_t     flags
);

    legv8_pkg::word_t b_op;
    legv8_pkg::word_t sum;
    logic             carry;
    logic             ovf;
    logic             is_sub;
    logic             c_flag;
    logic             v_flag;

    // one adder, subtract as a + ~b + 1
    assign is_sub = (alu_func == legv8_pkg::ALU_SUB);
    assign b_op   = is_sub ? ~b : b;
    assign {carry, sum} = {1'b0, a} + {1'b0, b_op} + {{`WORD_W{1'b0}}, is_sub};
    assign ovf = (a[`WORD_W-1] == b_op[`WORD_W-1]) && (sum[`WORD_W-1] != a[`WORD_W-1]);

    always_comb begin
        result = sum;
        c_flag = 1'b0;
        v_flag = 1'b0;
        case (alu_func)
            legv8_pkg::ALU_ADD, legv8_pkg::ALU_SUB: begin
                c_flag = carry;
                v_flag = ovf;
            end
            legv8_pkg::ALU_AND:    result = a & b;
            legv8_pkg::ALU_ORR:    result = a | b;
            legv8_pkg::ALU_EOR:    result = a ^ b;
            legv8_pkg::ALU_PASS_B: result = b;   // z then reflects b alone
            default:               result = sum;
        endcase
    end

    assign flags = {result[`WORD_W-1], result == '0, c_flag, v_flag};

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`include "legv8_macros.svh"

module register_file (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [4:0]       read_reg1,
    input  logic [4:0]       read_reg2,
    input  logic [4:0]       write_reg,
    input  legv8_pkg::word_t write_data,
    input  logic             reg_write,
    output legv8_pkg::word_t read_data1,
    output legv8_pkg::word_t read_data2
);

    localparam int XZR = `REG_COUNT - 1;

    // x0..x30 only, xzr has no storage
    legv8_pkg::word_t regs [0:`REG_COUNT-2];

    always_ff @(posedge clk) begin
        if (rst_n && reg_write && write_reg != XZR) begin
            regs[write_reg] <= write_data;
        end
    end

    assign read_data1 = (read_reg1 == XZR) ? '0 : regs[read_reg1];
    assign read_data2 = (read_reg2 == XZR) ? '0 : regs[read_reg2];

    // a write aimed at xzr must leave it reading zero afterwards
    assert property (@(posedge clk) disable iff (!rst_n)
        (reg_write && write_reg == XZR)
        |=> ((read_reg1 != XZR || read_data1 == '0) &&
             (read_reg2 != XZR || read_data2 == '0)))
        else $error("register_file: xzr reads non-zero after a write");

endmodule

// ==== logic/imm_extend.sv ====
`timescale 1ns/1ps
`include "legv8_macros.svh"

module imm_extend (
    input  legv8_pkg::instr_t instr,
    output legv8_pkg::word_t  imm
);

    logic [10:0] opcode;

    assign opcode = instr[31:21];

    always_comb begin
        casez (opcode)
            `ADDI, `ADDIS, `SUBI, `SUBIS, `ANDI, `ANDIS, `ORRI, `EORI: begin
                imm = {52'b0, instr[21:10]};  // aluimm, zero extended
            end
            `LDUR, `LDURB, `LDURH, `LDURSW, `STUR, `STURB, `STURH, `STURW: begin
                imm = {{55{instr[20]}}, instr[20:12]};
            end
            `B, `BL: begin
                imm = {{36{instr[25]}}, instr[25:0], 2'b00};
            end
            `CBZ, `CBNZ, `BCOND: begin
                imm = {{43{instr[23]}}, instr[23:5], 2'b00};
            end
            default: begin
                imm = '0;  // r-type and br carry no immediate
            end
        endcase
    end

endmodule

// ==== logic/pc_sequencer.sv ====
`timescale 1ns/1ps
`include "legv8_macros.svh"

module pc_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  legv8_pkg::branch_op_t branch_op,
    input  logic                  update_sreg,
    input  legv8_pkg::nzcv_t      alu_flags,
    input  logic [3:0]            cond,
    input  legv8_pkg::word_t      offset,
    input  legv8_pkg::word_t      target_reg,
    output legv8_pkg::word_t      pc,
    output legv8_pkg::word_t      pc_plus4
);

    legv8_pkg::nzcv_t sreg;
    legv8_pkg::word_t next_pc;
    logic             n, z, c, v;
    logic             cond_true;
    logic             taken;

    assign {n, z, c, v} = sreg;
    assign pc_plus4     = pc + 64'd4;

    // b.cond looks at the stored flags only
    always_comb begin
        case (cond)
            4'h0:    cond_true = z;                   // eq
            4'h1:    cond_true = !z;                  // ne
            4'h2:    cond_true = c;                   // hs
            4'h3:    cond_true = !c;                  // lo
            4'h4:    cond_true = n;                   // mi
            4'h5:    cond_true = !n;                  // pl
            4'h6:    cond_true = v;                   // vs
            4'h7:    cond_true = !v;                  // vc
            4'h8:    cond_true = c && !z;             // hi
            4'h9:    cond_true = !(c && !z);          // ls
            4'ha:    cond_true = (n == v);            // ge
            4'hb:    cond_true = (n != v);            // lt
            4'hc:    cond_true = !z && (n == v);      // gt
            4'hd:    cond_true = !(!z && (n == v));   // le
            default: cond_true = 1'b1;                // al
        endcase
    end

    always_comb begin
        case (branch_op)
            legv8_pkg::BR_ALWAYS:   taken = 1'b1;
            legv8_pkg::BR_COND:     taken = cond_true;
            legv8_pkg::BR_ZERO:     taken = alu_flags[2];    // live z from the alu
            legv8_pkg::BR_NOT_ZERO: taken = !alu_flags[2];
            default:                taken = 1'b0;
        endcase
        if (branch_op == legv8_pkg::BR_REG) begin
            next_pc = target_reg;
        end else begin
            next_pc = taken ? pc + offset : pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc   <= `RESET_PC;
            sreg <= '0;
        end else begin
            pc <= next_pc;
            if (update_sreg) sreg <= alu_flags;
        end
    end

    // offsets are word multiples, so only a bad br target can misalign
    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc_sequencer: pc not word aligned");

endmodule

// ==== logic/legv8_core.sv ====
`timescale 1ns/1ps
`include "legv8_macros.svh"

module legv8_core (
    input  logic              clk,
    input  logic              rst_n,
    output legv8_pkg::word_t  pc,
    input  legv8_pkg::instr_t instr,
    output legv8_pkg::word_t  mem_addr,
    output legv8_pkg::word_t  mem_wdata,
    output logic              mem_read,
    output logic              mem_write,
    input  legv8_pkg::word_t  mem_rdata
);

    logic                  readreg2_control;
    logic                  reg_write;
    logic                  alu_src;
    logic                  update_sreg;
    logic                  write_reg_src;
    legv8_pkg::alu_op_t    alu_op;
    legv8_pkg::mem_to_reg_t mem_to_reg;
    legv8_pkg::branch_op_t branch_op;
    legv8_pkg::alu_func_t  alu_func;
    logic [4:0]            read_reg2;
    logic [4:0]            write_reg;
    legv8_pkg::word_t      read_data1;
    legv8_pkg::word_t      read_data2;
    legv8_pkg::word_t      write_data;
    legv8_pkg::word_t      imm;
    legv8_pkg::word_t      alu_b;
    legv8_pkg::word_t      alu_result;
    legv8_pkg::nzcv_t      alu_flags;
    legv8_pkg::word_t      pc_plus4;

    control u_control (
        .opcode(instr[31:21]), .readreg2_control(readreg2_control),
        .mem_read(mem_read), .mem_write(mem_write), .reg_write(reg_write),
        .alu_src(alu_src), .update_sreg(update_sreg), .write_reg_src(write_reg_src),
        .alu_op(alu_op), .mem_to_reg(mem_to_reg), .branch_op(branch_op)
    );

    alu_control u_alu_control (.alu_op(alu_op), .opcode(instr[31:21]), .alu_func(alu_func));

    // rt for stores and cbz/cbnz, rm otherwise
    assign read_reg2 = readreg2_control ? instr[4:0] : instr[20:16];
    assign write_reg = write_reg_src ? `LINK_REG : instr[4:0];

    register_file u_register_file (
        .clk(clk), .rst_n(rst_n), .read_reg1(instr[9:5]), .read_reg2(read_reg2),
        .write_reg(write_reg), .write_data(write_data), .reg_write(reg_write),
        .read_data1(read_data1), .read_data2(read_data2)
    );

    imm_extend u_imm_extend (.instr(instr), .imm(imm));

    assign alu_b = alu_src ? imm : read_data2;

    alu u_alu (.a(read_data1), .b(alu_b), .alu_func(alu_func), .result(alu_result),
               .flags(alu_flags));

    assign mem_addr  = alu_result;
    assign mem_wdata = read_data2;

    always_comb begin
        case (mem_to_reg)
            legv8_pkg::WB_MEM: write_data = mem_rdata;
            legv8_pkg::WB_PC4: write_data = pc_plus4;  // bl link value
            default:           write_data = alu_result;
        endcase
    end

    pc_sequencer u_pc_sequencer (
        .clk(clk), .rst_n(rst_n), .branch_op(branch_op), .update_sreg(update_sreg),
        .alu_flags(alu_flags), .cond(instr[3:0]), .offset(imm), .target_reg(read_data1),
        .pc(pc), .pc_plus4(pc_plus4)
    );

endmodule

// ==== verification/legv8_core_tb.sv ====
`timescale 1ns/1ps
`include "legv8_macros.svh"

module legv8_core_tb;

    localparam int timeout_cycles = 2000;  // roughly ten times the whole program
    localparam logic [9:0] op_addi  = 10'b1001000100;
    localparam logic [9:0] op_subi  = 10'b1101000100;
    localparam logic [9:0] op_subis = 10'b1111000100;
    localparam logic [9:0] op_andi  = 10'b1001001000;
    localparam logic [9:0] op_eori  = 10'b1101001000;
    localparam logic [7:0] op_cbz   = 8'b10110100;
    localparam logic [7:0] op_cbnz  = 8'b10110101;
    localparam logic [7:0] op_bcond = 8'b01010100;
    localparam logic [5:0] op_b     = 6'b000101;
    localparam logic [5:0] op_bl    = 6'b100101;

    logic              clk;
    logic              rst_n;
    legv8_pkg::word_t  pc;
    legv8_pkg::instr_t instr;
    legv8_pkg::word_t  mem_addr;
    legv8_pkg::word_t  mem_wdata;
    logic              mem_read;
    logic              mem_write;
    legv8_pkg::word_t  mem_rdata;

    legv8_pkg::instr_t imem [0:1023];
    legv8_pkg::word_t  dmem [legv8_pkg::word_t];
    int                mem_rev;  // bumped on every memory write
    legv8_pkg::word_t  m_reg [0:31];
    legv8_pkg::nzcv_t  m_flags;
    legv8_pkg::word_t  m_pc;
    string             test_name;
    int                errors;
    int                cycles;
    integer            seed;

    legv8_core DUT (
        .clk(clk), .rst_n(rst_n), .pc(pc), .instr(instr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_read(mem_read), .mem_write(mem_write),
        .mem_rdata(mem_rdata)
    );

    assign instr = rst_n ? imem[pc[11:2]] : '0;  // zero word matches no opcode

    function automatic legv8_pkg::word_t stored_word(input legv8_pkg::word_t addr);
        if (dmem.exists(addr)) return dmem[addr];
        return ~addr;  // unwritten words
    endfunction

    always @(mem_addr or mem_rev) begin
        mem_rdata = (^mem_addr === 1'bx) ? '0 : stored_word(mem_addr);
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the program did not finish within %0d cycles", timeout_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input legv8_pkg::word_t expected,
                              input legv8_pkg::word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s data: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_pc(input string name, input legv8_pkg::word_t expected,
                            input legv8_pkg::word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s pc: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s strobe: expected %b actual %b", name, expected, actual);
        end
    endtask

    function automatic legv8_pkg::instr_t r_format(input logic [10:0] op, input logic [4:0] rd,
                                                   input logic [4:0] rn, input logic [4:0] rm);
        return {op, rm, 6'b0, rn, rd};
    endfunction

    function automatic legv8_pkg::instr_t i_format(input logic [9:0] op, input logic [4:0] rd,
                                                   input logic [4:0] rn, input logic [11:0] imm);
        return {op, imm, rn, rd};
    endfunction

    function automatic legv8_pkg::instr_t d_format(input logic [10:0] op, input logic [4:0] rt,
                                                   input logic [4:0] rn, input logic [8:0] off);
        return {op, off, 2'b00, rn, rt};
    endfunction

    function automatic legv8_pkg::instr_t b_format(input logic [5:0] op, input logic [25:0] off);
        return {op, off};
    endfunction

    function automatic legv8_pkg::instr_t cb_format(input logic [7:0] op, input logic [18:0] off,
                                                    input logic [4:0] rt);
        return {op, off, rt};
    endfunction

    // reference arithmetic where c is the unsigned carry (no borrow for sub)
    task automatic model_alu(input legv8_pkg::alu_func_t f, input legv8_pkg::word_t a,
                             input legv8_pkg::word_t b, output legv8_pkg::word_t res,
                             output legv8_pkg::nzcv_t fl);
        logic [64:0] wide;
        logic        c;
        logic        v;
        c = 1'b0;
        v = 1'b0;
        case (f)
            legv8_pkg::ALU_ADD: begin
                wide = {1'b0, a} + {1'b0, b};
                res  = wide[63:0];
                c    = wide[64];
                v    = (a[63] == b[63]) && (res[63] != a[63]);
            end
            legv8_pkg::ALU_SUB: begin
                res = a - b;
                c   = (a >= b);
                v   = (a[63] != b[63]) && (res[63] != a[63]);
            end
            legv8_pkg::ALU_AND: res = a & b;
            legv8_pkg::ALU_ORR: res = a | b;
            legv8_pkg::ALU_EOR: res = a ^ b;
            default:            res = b;
        endcase
        fl = {res[63], res == '0, c, v};
    endtask

    function automatic logic cond_holds(input logic [3:0] cond, input legv8_pkg::nzcv_t fl);
        logic n;
        logic z;
        logic c;
        logic v;
        {n, z, c, v} = fl;
        case (cond)
            4'h0: return z;
            4'h1: return !z;
            4'h2: return c;
            4'h3: return !c;
            4'h4: return n;
            4'h5: return !n;
            4'h6: return v;
            4'h7: return !v;
            4'h8: return c && !z;
            4'h9: return !c || z;
            4'ha: return n == v;
            4'hb: return n != v;
            4'hc: return !z && (n == v);
            4'hd: return z || (n != v);
            default: return 1'b1;
        endcase
    endfunction

    // place the word where the model pc points, then sample mid-cycle
    task automatic issue(input legv8_pkg::instr_t ins);
        @(posedge clk);
        imem[m_pc[11:2]] <= ins;
        @(negedge clk);
        check_pc(test_name, m_pc, pc);
    endtask

    task automatic advance(input logic taken, input longint off);
        m_pc = taken ? m_pc + off * 4 : m_pc + 4;
    endtask

    task automatic write_memory(input legv8_pkg::word_t addr, input legv8_pkg::word_t data);
        dmem[addr] = data;
        mem_rev++;
    endtask

    task automatic reg_op(input logic [10:0] op, input legv8_pkg::alu_func_t f,
                          input logic set_flags, input logic [4:0] rd, input logic [4:0] rn,
                          input logic [4:0] rm);
        legv8_pkg::word_t res;
        legv8_pkg::nzcv_t fl;
        issue(r_format(op, rd, rn, rm));
        model_alu(f, m_reg[rn], m_reg[rm], res, fl);
        if (rd != 5'd31) m_reg[rd] = res;
        if (set_flags) m_flags = fl;
        advance(1'b0, 0);
    endtask

    task automatic imm_op(input logic [9:0] op, input legv8_pkg::alu_func_t f,
                          input logic set_flags, input logic [4:0] rd, input logic [4:0] rn,
                          input logic [11:0] imm);
        legv8_pkg::word_t res;
        legv8_pkg::nzcv_t fl;
        issue(i_format(op, rd, rn, imm));
        model_alu(f, m_reg[rn], {52'b0, imm}, res, fl);
        if (rd != 5'd31) m_reg[rd] = res;
        if (set_flags) m_flags = fl;
        advance(1'b0, 0);
    endtask

    task automatic store_check(input logic [4:0] rt, input logic [4:0] rn, input longint off);
        legv8_pkg::word_t addr;
        addr = m_reg[rn] + off;
        issue(d_format(`STUR, rt, rn, off[8:0]));
        check_bit(test_name, 1'b1, mem_write);
        check_bit(test_name, 1'b0, mem_read);
        check_word(test_name, addr, mem_addr);
        check_word(test_name, m_reg[rt], mem_wdata);
        write_memory(addr, m_reg[rt]);
        advance(1'b0, 0);
    endtask

    task automatic load_run(input logic [4:0] rt, input logic [4:0] rn, input longint off);
        legv8_pkg::word_t addr;
        addr = m_reg[rn] + off;
        issue(d_format(`LDUR, rt, rn, off[8:0]));
        check_bit(test_name, 1'b1, mem_read);
        check_bit(test_name, 1'b0, mem_write);
        check_word(test_name, addr, mem_addr);
        if (rt != 5'd31) m_reg[rt] = stored_word(addr);
        advance(1'b0, 0);
    endtask

    task automatic bcond_run(input logic [3:0] cond, input longint off);
        issue(cb_format(op_bcond, off[18:0], {1'b0, cond}));
        advance(cond_holds(cond, m_flags), off);
    endtask

    task automatic cb_run(input logic nonzero, input logic [4:0] rt, input longint off);
        legv8_pkg::word_t v;
        v = m_reg[rt];
        issue(cb_format(nonzero ? op_cbnz : op_cbz, off[18:0], rt));
        m_flags = {v[63], v == '0, 2'b00};  // cb forms also load the flags
        advance(nonzero ? (v != '0) : (v == '0), off);
    endtask

    task automatic jump_run(input logic link, input longint off);
        issue(b_format(link ? op_bl : op_b, off[25:0]));
        if (link) m_reg[30] = m_pc + 4;
        advance(1'b1, off);
    endtask

    task automatic br_run(input logic [4:0] rn);
        issue(r_format(`BR, 5'd0, rn, 5'd31));
        m_pc = m_reg[rn];
    endtask

    task automatic reset_and_zero_reg();
        test_name = "reset_zero_reg";
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_pc(test_name, `RESET_PC, pc);
        check_bit(test_name, 1'b0, mem_write);
        advance(1'b0, 0);  // the zero word at the reset pc
        imm_op(op_addi, legv8_pkg::ALU_ADD, 1'b0, 5'd1, 5'd31, 12'h200);
        imm_op(op_addi, legv8_pkg::ALU_ADD, 1'b0, 5'd31, 5'd31, 12'h5a5);
        store_check(5'd31, 5'd1, 8);
    endtask

    task automatic arith_logic();
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] c;
        test_name = "arith_logic";
        repeat (4) begin
            a = 12'($random(seed));
            b = 12'($random(seed));
            c = 12'($random(seed));
            imm_op(op_addi, legv8_pkg::ALU_ADD, 1'b0, 5'd2, 5'd31, a);
            imm_op(op_addi, legv8_pkg::ALU_ADD, 1'b0, 5'd3, 5'd31, b);
            reg_op(`SUB, legv8_pkg::ALU_SUB, 1'b0, 5'd4, 5'd31, 5'd3);  // negative operand
            reg_op(`ADD, legv8_pkg::ALU_ADD, 1'b0, 5'd5, 5'd2, 5'd4);
            reg_op(`SUB, legv8_pkg::ALU_SUB, 1'b0, 5'd6, 5'd2, 5'd3);
            reg_op(`AND, legv8_pkg::ALU_AND, 1'b0, 5'd7, 5'd5, 5'd4);
            reg_op(`ORR, legv8_pkg::ALU_ORR, 1'b0, 5'd8, 5'd2, 5'd4);
            imm_op(op_eori, legv8_pkg::ALU_EOR, 1'b0, 5'd9, 5'd4, c);
            imm_op(op_andi, legv8_pkg::ALU_AND, 1'b0, 5'd10, 5'd5, c);
            for (int k = 5; k <= 10; k++) store_check(5'(k), 5'd1, (k - 5) * 8 - 16);
        end
    endtask

    task automatic load_words();
        test_name = "load";
        write_memory(64'h300, 64'h0123_4567_89ab_cdef);
        write_memory(64'h308, {$random(seed), $random(seed)});
        write_memory(64'h2f8, 64'h7fff_ffff_ffff_ffff);
        write_memory(64'h310, 64'h8000_0000_0000_0000);
        imm_op(op_addi, legv8_pkg::ALU_ADD, 1'b0, 5'd11, 5'd31, 12'h300);
        load_run(5'd12, 5'd11, 0);
        store_check(5'd12, 5'd1, 64);
        load_run(5'd13, 5'd11, 8);
        store_check(5'd13, 5'd1, 72);
        load_run(5'd14, 5'd11, -8);
        store_check(5'd14, 5'd1, 80);
        load_run(5'd15, 5'd11, 16);
        store_check(5'd15, 5'd1, 88);
    endtask

    task automatic all_conditions();
        for (int c = 0; c < 15; c++) bcond_run(4'(c), (c % 2 == 1) ? -2 : 3);
    endtask

    task automatic flags_bcond();
        test_name = "flags_bcond";
        imm_op(op_addi, legv8_pkg::ALU_ADD, 1'b0, 5'd16, 5'd31, 12'd1);
        imm_op(op_subi, legv8_pkg::ALU_SUB, 1'b0, 5'd17, 5'd31, 12'd1);
        imm_op(op_addi, legv8_pkg::ALU_ADD, 1'b0, 5'd18, 5'd31, 12'd7);
        imm_op(op_addi, legv8_pkg::ALU_ADD, 1'b0, 5'd19, 5'd31, 12'h123);
        reg_op(`SUBS, legv8_pkg::ALU_SUB, 1'b1, 5'd31, 5'd18, 5'd18);  // cmp of equal values
        all_conditions();
        reg_op(`SUBS, legv8_pkg::ALU_SUB, 1'b1, 5'd20, 5'd18, 5'd19);
        all_conditions();
        reg_op(`ADDS, legv8_pkg::ALU_ADD, 1'b1, 5'd20, 5'd14, 5'd16);  // signed overflow
        all_conditions();
        reg_op(`ADDS, legv8_pkg::ALU_ADD, 1'b1, 5'd20, 5'd17, 5'd17);
        all_conditions();
        reg_op(`SUBS, legv8_pkg::ALU_SUB, 1'b1, 5'd20, 5'd15, 5'd16);
        all_conditions();
        imm_op(op_subis, legv8_pkg::ALU_SUB, 1'b1, 5'd31, 5'd16, 12'd5);  // cmpi
        all_conditions();
    endtask

    task automatic cbz_cbnz();
        test_name = "cbz_cbnz";
        imm_op(op_addi, legv8_pkg::ALU_ADD, 1'b0, 5'd21, 5'd31, 12'd0);
        reg_op(`SUB, legv8_pkg::ALU_SUB, 1'b0, 5'd22, 5'd31, 5'd16);
        for (int t = 0; t < 4; t++) begin
            // z and c set first, so the cb flag load shows up in eq and hs
            reg_op(`SUBS, legv8_pkg::ALU_SUB, 1'b1, 5'd31, 5'd18, 5'd18);
            cb_run(t[0], (t < 2) ? 5'd21 : 5'd22, (t == 3) ? -2 : 4);
            bcond_run(4'h0, 2);
            bcond_run(4'h4, 2);
            bcond_run(4'h2, 2);
        end
    endtask

    task automatic jumps();
        test_name = "b_bl_br";
        jump_run(1'b0, 5);
        jump_run(1'b0, -3);
        jump_run(1'b1, 6);
        store_check(5'd30, 5'd1, 96);
        br_run(5'd30);
        jump_run(1'b1, -4);
        store_check(5'd30, 5'd1, 104);
        br_run(5'd30);
        issue('0);  // lands on the return address
        advance(1'b0, 0);
    endtask

    initial begin
        rst_n     = 1'b0;
        mem_rdata = '0;
        errors    = 0;
        cycles    = 0;
        mem_rev   = 0;
        seed      = 32'h51c9;
        m_pc      = `RESET_PC;
        m_flags   = '0;
        for (int i = 0; i < 1024; i++) imem[i] = '0;
        for (int i = 0; i < 32; i++) m_reg[i] = '0;
        reset_and_zero_reg();
        arith_logic();
        load_words();
        flags_bcond();
        cbz_cbnz();
        jumps();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
logic/legv8_pkg.sv
logic/control.sv
logic/alu_control.sv
logic/alu.sv
logic/register_file.sv
logic/imm_extend.sv
logic/pc_sequencer.sv
logic/legv8_core.sv
verification/legv8_core_tb.sv
